//--- spw_char_pkg.sv
`default_nettype none

package spw_char_pkg;

	// --------------------------------------------------
	// Character layout on the link
	// --------------------------------------------------

	// Two control bits, sent LSB first after the flag
	typedef enum logic [1:0]
	{
		FCT = 2'b00, // Flow control token
		EOP = 2'b01, // Normal end of packet
		EEP = 2'b10, // Error end of packet
		ESC = 2'b11  // Prefix of NULL and time codes
	} ctrl_code_t;

	typedef logic [8:0] data_flag_t;  // Bit 8 marks EOP/EEP, 7..0 data
	typedef logic [7:0] time_code_t;  // Time code as received

	localparam int CTRL_CHAR_BITS = 4;  // Parity, flag, 2 code bits
	localparam int DATA_CHAR_BITS = 10; // Parity, flag, 8 data bits

	// Marker words written to the buffer in place of a data byte
	localparam data_flag_t EOP_WORD = 9'h100;
	localparam data_flag_t EEP_WORD = 9'h101;

	// --------------------------------------------------
	// Odd parity across the character boundary
	// --------------------------------------------------

	// Parity bit that makes previous payload + this parity + this flag odd
	function automatic logic parity_bit(input logic prev_payload_par, input logic is_ctrl);
		return ~(prev_payload_par ^ is_ctrl);
	endfunction

endpackage

`default_nettype wire

//--- spw_rx_cfg_pkg.sv
`default_nettype none

package spw_rx_cfg_pkg;

	// --------------------------------------------------
	// Receiver sampling constants
	// --------------------------------------------------

	// Flops per line before edge detect, at least 2
	localparam int SYNC_STAGES = 2;

	// Shortest bit period, in sample clocks, the receiver can follow
	localparam int MIN_BIT_CLKS = 3;

endpackage

`default_nettype wire

//--- spw_rx_bit_recovery.sv
`default_nettype none
`timescale 1ns/1ps

module spw_rx_bit_recovery
(
	input  wire  posedge_clk,
	input  wire  rx_resetn,
	input  wire  rx_din,
	input  wire  rx_sin,
	output logic bit_strobe,
	output logic bit_value,
	output logic rx_got_bit
);
	import spw_rx_cfg_pkg::*;

	logic [SYNC_STAGES-1:0] din_sync; // Data line synchroniser
	logic [SYNC_STAGES-1:0] sin_sync; // Strobe line synchroniser
	logic din_prev;
	logic sin_prev;
	logic din_chg;
	logic sin_chg;

	assign din_chg = din_sync[SYNC_STAGES-1] ^ din_prev;
	assign sin_chg = sin_sync[SYNC_STAGES-1] ^ sin_prev;

	// Both lines idle low out of reset, as the transmitter leaves them
	always_ff @(posedge posedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			din_sync   <= '0;
			sin_sync   <= '0;
			din_prev   <= 1'b0;
			sin_prev   <= 1'b0;
			bit_strobe <= 1'b0;
			rx_got_bit <= 1'b0;
		end
		else
		begin
			din_sync   <= {din_sync[SYNC_STAGES-2:0], rx_din};
			sin_sync   <= {sin_sync[SYNC_STAGES-2:0], rx_sin};
			din_prev   <= din_sync[SYNC_STAGES-1];
			sin_prev   <= sin_sync[SYNC_STAGES-1];
			bit_strobe <= din_chg ^ sin_chg; // One bit per DS transition
			if (din_chg ^ sin_chg)
				rx_got_bit <= 1'b1; // Sticky, first activity seen
		end
	end

	always_ff @(posedge posedge_clk)
		bit_value <= din_sync[SYNC_STAGES-1]; // New Data level is the bit

	// DS encoding toggles exactly one line per bit
	a_ds_one_line: assert property (@(posedge posedge_clk) disable iff (!rx_resetn)
		!(din_chg && sin_chg));

	// Line changes spaced by at least the minimum bit period
	for (genvar k = 1; k < MIN_BIT_CLKS; k++)
	begin : g_min_period
		a_bit_period: assert property (@(posedge posedge_clk) disable iff (!rx_resetn)
			(din_chg || sin_chg) |-> !$past(din_chg || sin_chg, k));
	end

endmodule

`default_nettype wire

//--- spw_rx_char_shift.sv
`default_nettype none
`timescale 1ns/1ps

module spw_rx_char_shift
(
	input  wire        posedge_clk,
	input  wire        rx_resetn,
	input  wire        bit_strobe,
	input  wire        bit_value,
	output logic       char_done,
	output logic       char_is_ctrl,
	output logic [7:0] char_payload,
	output logic       char_parity
);
	import spw_char_pkg::*;

	localparam logic [3:0] CTRL_LEN = 4'(CTRL_CHAR_BITS);
	localparam logic [3:0] DATA_LEN = 4'(DATA_CHAR_BITS);

	logic [3:0] bit_cnt;  // Bits taken of the current character
	logic [3:0] cnt_base; // Count seen by the incoming bit
	logic [2:0] pay_idx;  // Payload slot of the incoming bit
	logic       last_bit;

	assign cnt_base = char_done ? 4'd0 : bit_cnt; // Restart after a character
	assign pay_idx  = cnt_base[2:0] - 3'd2;       // Payload starts at bit 2

	// Flag is known from bit 2 on, so stale flag is harmless at 0 and 1
	assign last_bit = char_is_ctrl ? (cnt_base == CTRL_LEN - 4'd1)
	                               : (cnt_base == DATA_LEN - 4'd1);

	always_ff @(posedge posedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			bit_cnt   <= 4'd0;
			char_done <= 1'b0;
		end
		else
		begin
			char_done <= bit_strobe && last_bit;
			bit_cnt   <= bit_strobe ? cnt_base + 4'd1 : cnt_base;
		end
	end

	// Character fields, stable from char_done until the next parity bit
	always_ff @(posedge posedge_clk)
	begin
		if (bit_strobe)
		begin
			if (cnt_base == 4'd0)
			begin
				char_parity  <= bit_value;
				char_payload <= '0; // Upper bits stay clear for control chars
			end
			else if (cnt_base == 4'd1)
				char_is_ctrl <= bit_value; // 1 means control character
			else
				char_payload[pay_idx] <= bit_value; // LSB first
		end
	end

	// Length agrees with the flag taken two bits into the character
	a_char_len: assert property (@(posedge posedge_clk) disable iff (!rx_resetn)
		char_done |-> (char_is_ctrl ? (bit_cnt == CTRL_LEN) : (bit_cnt == DATA_LEN)));

endmodule

`default_nettype wire

//--- spw_rx_parity.sv
`default_nettype none
`timescale 1ns/1ps

module spw_rx_parity
(
	input  wire        posedge_clk,
	input  wire        rx_resetn,
	input  wire        char_done,
	input  wire        char_is_ctrl,
	input  wire  [7:0] char_payload,
	input  wire        char_parity,
	output logic       parity_err
);
	import spw_char_pkg::*;

	logic prev_par; // Parity of last payload, 0 while none seen

	// Only meaningful while char_done is high
	assign parity_err = char_done && (char_parity != parity_bit(prev_par, char_is_ctrl));

	always_ff @(posedge posedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
			prev_par <= 1'b0;
		else if (char_done)
			prev_par <= ^char_payload; // Control code has zeros above bit 1
	end

endmodule

`default_nettype wire

//--- spw_rx_char_fsm.sv
`default_nettype none
`timescale 1ns/1ps

module spw_rx_char_fsm
(
	input  wire                      posedge_clk,
	input  wire                      rx_resetn,
	input  wire                      char_done,
	input  wire                      char_is_ctrl,
	input  wire  [7:0]               char_payload,
	input  wire                      parity_err,
	output logic                     data_load,
	output spw_char_pkg::data_flag_t data_word,
	output logic                     time_load,
	output spw_char_pkg::time_code_t time_word,
	output logic                     rx_buffer_write,
	output logic                     rx_tick_out,
	output logic                     rx_got_fct,
	output logic                     rx_got_null,
	output logic                     rx_got_nchar,
	output logic                     rx_error
);
	import spw_char_pkg::*;

	typedef enum logic [1:0] {IDLE, GOT_ESC, ERROR} state_t;

	state_t     state;
	state_t     state_nxt;
	ctrl_code_t code;     // Control code of the current character
	logic       do_fct;
	logic       do_null;
	logic       do_nchar;

	assign code = ctrl_code_t'(char_payload[1:0]);

	// --------------------------------------------------
	// Character decode, evaluated in the char_done cycle
	// --------------------------------------------------
	// Loads go out unregistered so the hold registers update
	// together with the registered strobes below.
	// Errors count only once the link has seen a NULL.
	always_comb
	begin
		state_nxt = state;
		data_load = 1'b0;
		time_load = 1'b0;
		do_fct    = 1'b0;
		do_null   = 1'b0;
		do_nchar  = 1'b0;
		data_word = {1'b0, char_payload}; // N-Char, marker bit clear
		time_word = char_payload;
		if (char_done && state != ERROR)
		begin
			if (parity_err && rx_got_null)
				state_nxt = ERROR;
			else if (state == GOT_ESC)
			begin
				state_nxt = IDLE;
				if (!char_is_ctrl)
					time_load = rx_got_null; // ESC + data is a time code
				else if (code == FCT)
					do_null = 1'b1;          // ESC + FCT is NULL
				else if (rx_got_null)
					state_nxt = ERROR;       // ESC + ESC/EOP/EEP
			end
			else if (!char_is_ctrl)
			begin
				data_load = rx_got_null;
				do_nchar  = rx_got_null;
			end
			else
			begin
				case (code)
					FCT: do_fct = rx_got_null;
					EOP:
					begin
						data_load = rx_got_null;
						data_word = EOP_WORD;
					end
					EEP:
					begin
						data_load = rx_got_null;
						data_word = EEP_WORD;
					end
					ESC: state_nxt = GOT_ESC; // Wait for second half
				endcase
			end
		end
	end

	// --------------------------------------------------
	// Registered strobes and sticky status
	// --------------------------------------------------
	always_ff @(posedge posedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			state           <= IDLE;
			rx_buffer_write <= 1'b0;
			rx_tick_out     <= 1'b0;
			rx_got_fct      <= 1'b0;
			rx_got_null     <= 1'b0;
			rx_got_nchar    <= 1'b0;
			rx_error        <= 1'b0;
		end
		else
		begin
			state           <= state_nxt;
			rx_buffer_write <= data_load;
			rx_tick_out     <= time_load;
			rx_got_fct      <= do_fct;
			rx_got_null     <= rx_got_null | do_null;
			rx_got_nchar    <= rx_got_nchar | do_nchar;
			rx_error        <= (state_nxt == ERROR); // ERROR holds until reset
		end
	end

	// One payload per character, never both
	a_one_load: assert property (@(posedge posedge_clk) disable iff (!rx_resetn)
		!(data_load && time_load));

endmodule

`default_nettype wire

//--- spw_rx_hold.sv
`default_nettype none
`timescale 1ns/1ps

module spw_rx_hold
#(
	parameter type payload_t = logic [7:0]
)
(
	input  wire           posedge_clk,
	input  wire           rx_resetn,
	input  wire           load,
	input  wire payload_t din,
	output payload_t      dout
);

	// Keeps last delivered value between strobes
	always_ff @(posedge posedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
			dout <= '0;
		else if (load)
			dout <= din; // Visible with the matching output strobe
	end

endmodule

`default_nettype wire

//--- spw_rx_top.sv
`default_nettype none
`timescale 1ns/1ps

module spw_rx_top
(
	input  wire                      posedge_clk,
	input  wire                      rx_resetn,
	input  wire                      rx_din,
	input  wire                      rx_sin,
	output wire                      rx_error,
	output wire                      rx_got_bit,
	output wire                      rx_got_null,
	output wire                      rx_got_nchar,
	output wire                      rx_got_time_code,
	output wire                      rx_got_fct,
	output wire spw_char_pkg::data_flag_t rx_data_flag,
	output wire                      rx_buffer_write,
	output wire spw_char_pkg::time_code_t rx_time_out,
	output wire                      rx_tick_out
);
	import spw_char_pkg::*;

	wire             bit_strobe;
	wire             bit_value;
	wire             char_done;
	wire             char_is_ctrl;
	wire [7:0]       char_payload;
	wire             char_parity;
	wire             parity_err;
	wire             data_load;
	wire data_flag_t data_word;
	wire             time_load;
	wire time_code_t time_word;

	assign rx_got_time_code = rx_tick_out; // Status name of the tick

	// --------------------------------------------------
	// Bits, then characters, then decode
	// --------------------------------------------------
	spw_rx_bit_recovery i_bit_recovery (
		.posedge_clk (posedge_clk),
		.rx_resetn   (rx_resetn),
		.rx_din      (rx_din),
		.rx_sin      (rx_sin),
		.bit_strobe  (bit_strobe),
		.bit_value   (bit_value),
		.rx_got_bit  (rx_got_bit)
	);

	spw_rx_char_shift i_char_shift (
		.posedge_clk  (posedge_clk),
		.rx_resetn    (rx_resetn),
		.bit_strobe   (bit_strobe),
		.bit_value    (bit_value),
		.char_done    (char_done),
		.char_is_ctrl (char_is_ctrl),
		.char_payload (char_payload),
		.char_parity  (char_parity)
	);

	spw_rx_parity i_parity (
		.posedge_clk  (posedge_clk),
		.rx_resetn    (rx_resetn),
		.char_done    (char_done),
		.char_is_ctrl (char_is_ctrl),
		.char_payload (char_payload),
		.char_parity  (char_parity),
		.parity_err   (parity_err)
	);

	spw_rx_char_fsm i_char_fsm (
		.posedge_clk     (posedge_clk),
		.rx_resetn       (rx_resetn),
		.char_done       (char_done),
		.char_is_ctrl    (char_is_ctrl),
		.char_payload    (char_payload),
		.parity_err      (parity_err),
		.data_load       (data_load),
		.data_word       (data_word),
		.time_load       (time_load),
		.time_word       (time_word),
		.rx_buffer_write (rx_buffer_write),
		.rx_tick_out     (rx_tick_out),
		.rx_got_fct      (rx_got_fct),
		.rx_got_null     (rx_got_null),
		.rx_got_nchar    (rx_got_nchar),
		.rx_error        (rx_error)
	);

	// Output payload registers
	spw_rx_hold #(.payload_t(data_flag_t)) i_data_hold (
		.posedge_clk (posedge_clk),
		.rx_resetn   (rx_resetn),
		.load        (data_load),
		.din         (data_word),
		.dout        (rx_data_flag)
	);

	spw_rx_hold #(.payload_t(time_code_t)) i_time_hold (
		.posedge_clk (posedge_clk),
		.rx_resetn   (rx_resetn),
		.load        (time_load),
		.din         (time_word),
		.dout        (rx_time_out)
	);

endmodule

`default_nettype wire

//--- tb_spw_rx.sv
`default_nettype none
`timescale 1ns/1ps

module tb_spw_rx;
	import spw_char_pkg::*;
	import spw_rx_cfg_pkg::*;

	// --------------------------------------------------
	// Run constants
	// --------------------------------------------------
	localparam int CLK_PERIOD = 20;
	localparam int RESET_CLKS = 10;
	localparam int DRIVE_DLY  = 2;  // ns after the rising edge
	localparam int BIT_CLKS   = 8;  // Clocks per line bit
	localparam int N_DATA     = 200;
	localparam int N_TIME     = 30;
	localparam int MAX_CHARS  = 3 * N_DATA + 3 * N_TIME + 40; // NULL counts as two
	localparam int WATCHDOG_NS = 2 * MAX_CHARS * DATA_CHAR_BITS * BIT_CLKS * CLK_PERIOD;
	localparam int DRAIN_CLKS = SYNC_STAGES + 3 + BIT_CLKS;
	localparam logic [31:0] SEED = 32'h1810_763b;

	// Kind of an expected item, bits 10:9
	localparam logic [1:0] K_NONE  = 2'd0;
	localparam logic [1:0] K_WRITE = 2'd1;
	localparam logic [1:0] K_TICK  = 2'd2;
	localparam logic [1:0] K_FCT   = 2'd3;

	logic       posedge_clk = 1'b0;
	logic       rx_resetn;
	logic       rx_din;
	logic       rx_sin;
	wire        rx_error;
	wire        rx_got_bit;
	wire        rx_got_null;
	wire        rx_got_nchar;
	wire        rx_got_time_code;
	wire        rx_got_fct;
	data_flag_t rx_data_flag;
	wire        rx_buffer_write;
	time_code_t rx_time_out;
	wire        rx_tick_out;

	logic [10:0] exp_q[$];    // Expected outputs, in line order
	logic        ref_esc;     // Reference decode state
	logic        ref_null;
	logic        ref_err;
	logic        tx_prev_par; // Parity of last sent payload
	time_code_t  last_time;   // Time code the hold register must show
	int          val_errs = 0;
	int          other_errs = 0;

	always #(CLK_PERIOD / 2) posedge_clk = ~posedge_clk;

	spw_rx_top i_dut (
		.posedge_clk      (posedge_clk),
		.rx_resetn        (rx_resetn),
		.rx_din           (rx_din),
		.rx_sin           (rx_sin),
		.rx_error         (rx_error),
		.rx_got_bit       (rx_got_bit),
		.rx_got_null      (rx_got_null),
		.rx_got_nchar     (rx_got_nchar),
		.rx_got_time_code (rx_got_time_code),
		.rx_got_fct       (rx_got_fct),
		.rx_data_flag     (rx_data_flag),
		.rx_buffer_write  (rx_buffer_write),
		.rx_time_out      (rx_time_out),
		.rx_tick_out      (rx_tick_out)
	);

	// --------------------------------------------------
	// Reference decode of one character
	// --------------------------------------------------
	// Nothing is written or pulsed before the first NULL
	function automatic logic [10:0] ref_decode(input logic is_ctrl, input logic [7:0] payload,
		input logic par_bad);
		logic [10:0] item;
		item = {K_NONE, 9'h000};
		if (ref_err)
			return item; // Dead until reset
		if (par_bad && ref_null)
		begin
			ref_err = 1'b1;
			return item;
		end
		if (ref_esc)
		begin
			ref_esc = 1'b0;
			if (!is_ctrl)
			begin
				if (ref_null)
					item = {K_TICK, 1'b0, payload}; // ESC + data
			end
			else if (payload[1:0] == FCT)
				ref_null = 1'b1;
			else if (ref_null)
				ref_err = 1'b1; // ESC + ESC/EOP/EEP
		end
		else if (!is_ctrl)
		begin
			if (ref_null)
				item = {K_WRITE, 1'b0, payload};
		end
		else
		begin
			case (payload[1:0])
				FCT: if (ref_null) item = {K_FCT, 9'h000};
				EOP: if (ref_null) item = {K_WRITE, 9'h100};
				EEP: if (ref_null) item = {K_WRITE, 9'h101};
				default: ref_esc = 1'b1;
			endcase
		end
		return item;
	endfunction

	// --------------------------------------------------
	// Checks
	// --------------------------------------------------
	task automatic check_level(input string name, input logic got, input logic exp);
		assert (got === exp)
		else
		begin
			val_errs++;
			$display("ERR %s exp=%h got=%h at %0t", name, exp, got, $time);
		end
	endtask

	task automatic check_word(input string name, input logic [8:0] got, input logic [8:0] exp);
		assert (got === exp)
		else
		begin
			val_errs++;
			$display("ERR %s exp=%h got=%h at %0t", name, exp, got, $time);
		end
	endtask

	task automatic check_drained(input string phase);
		assert (exp_q.size() == 0)
		else
		begin
			other_errs++;
			$display("%0d expected outputs never appeared after %s", exp_q.size(), phase);
			exp_q.delete();
		end
	endtask

	task automatic check_idle();
		check_level("rx_got_bit", rx_got_bit, 1'b0);
		check_level("rx_got_null", rx_got_null, 1'b0);
		check_level("rx_got_nchar", rx_got_nchar, 1'b0);
		check_level("rx_error", rx_error, 1'b0);
		check_level("rx_buffer_write", rx_buffer_write, 1'b0);
		check_level("rx_tick_out", rx_tick_out, 1'b0);
		check_level("rx_got_fct", rx_got_fct, 1'b0);
		check_word("rx_data_flag", rx_data_flag, 9'h000);
		check_word("rx_time_out", {1'b0, rx_time_out}, 9'h000);
	endtask

	// --------------------------------------------------
	// Encoder, Data/Strobe on the line
	// --------------------------------------------------
	task automatic send_bit(input logic b);
		@(posedge posedge_clk);
		#DRIVE_DLY;
		if (b == rx_din)
			rx_sin = ~rx_sin; // Strobe toggles when Data repeats
		rx_din = b;
		repeat (BIT_CLKS - 1) @(posedge posedge_clk);
	endtask

	task automatic send_char(input logic is_ctrl, input logic [7:0] payload,
		input logic flip_par);
		logic [10:0] item;
		logic        par;
		int          n_pay;
		n_pay = is_ctrl ? 2 : 8;
		par   = ~(tx_prev_par ^ is_ctrl); // Odd count with previous payload
		if (flip_par)
			par = ~par;
		item = ref_decode(is_ctrl, payload, flip_par);
		if (item[10:9] != K_NONE)
			exp_q.push_back(item);
		send_bit(par);
		send_bit(is_ctrl);
		for (int i = 0; i < n_pay; i++)
			send_bit(payload[i]); // LSB first
		tx_prev_par = is_ctrl ? ^payload[1:0] : ^payload;
	endtask

	task automatic send_ctrl(input ctrl_code_t code);
		send_char(1'b1, {6'b0, code}, 1'b0);
	endtask

	task automatic send_data(input logic [7:0] b);
		send_char(1'b0, b, 1'b0);
	endtask

	task automatic send_null();
		send_ctrl(ESC);
		send_ctrl(FCT);
	endtask

	task automatic send_time(input logic [7:0] t);
		send_ctrl(ESC);
		send_data(t);
	endtask

	task automatic settle();
		repeat (DRAIN_CLKS) @(posedge posedge_clk);
		#DRIVE_DLY;
	endtask

	task automatic apply_reset();
		@(posedge posedge_clk);
		#DRIVE_DLY;
		rx_resetn   = 1'b0;
		rx_din      = 1'b0; // Lines idle low
		rx_sin      = 1'b0;
		ref_esc     = 1'b0;
		ref_null    = 1'b0;
		ref_err     = 1'b0;
		tx_prev_par = 1'b0;
		last_time   = '0;
		exp_q.delete();
		repeat (RESET_CLKS) @(posedge posedge_clk);
		#DRIVE_DLY;
		rx_resetn = 1'b1;
	endtask

	// --------------------------------------------------
	// Comparing process, mid-cycle sampling
	// --------------------------------------------------
	initial
	begin : compare
		logic [10:0] item;
		wait (rx_resetn === 1'b1);
		forever
		begin
			@(negedge posedge_clk);
			if (rx_buffer_write || rx_tick_out || rx_got_fct || rx_got_time_code)
			begin
				if (exp_q.size() == 0)
				begin
					other_errs++;
					$display("Output strobe at %0t with no character expected", $time);
				end
				else
				begin
					item = exp_q.pop_front();
					check_level("rx_buffer_write", rx_buffer_write, item[10:9] == K_WRITE);
					check_level("rx_tick_out", rx_tick_out, item[10:9] == K_TICK);
					check_level("rx_got_time_code", rx_got_time_code, item[10:9] == K_TICK);
					check_level("rx_got_fct", rx_got_fct, item[10:9] == K_FCT);
					if (item[10:9] == K_WRITE)
						check_word("rx_data_flag", rx_data_flag, item[8:0]);
					if (item[10:9] == K_TICK)
					begin
						check_word("rx_time_out", {1'b0, rx_time_out}, item[8:0]);
						last_time = item[7:0];
					end
				end
			end
			if (!rx_tick_out)
				check_word("rx_time_out", {1'b0, rx_time_out}, {1'b0, last_time}); // Held
		end
	end

	// --------------------------------------------------
	// Stimulus
	// --------------------------------------------------
	initial
	begin : stimulus
		int pick;
		void'($urandom(SEED));
		rx_resetn = 1'b0;
		rx_din    = 1'b0;
		rx_sin    = 1'b0;
		apply_reset();
		repeat (4) @(posedge posedge_clk);
		#DRIVE_DLY;
		check_idle(); // No line activity yet

		send_data(8'($urandom)); // Ignored ahead of NULL
		send_ctrl(FCT);
		send_ctrl(EOP);
		send_data(8'($urandom));
		settle();
		check_level("rx_got_null", rx_got_null, 1'b0);
		send_null();
		settle();
		check_level("rx_got_null", rx_got_null, 1'b1);
		check_level("rx_got_bit", rx_got_bit, 1'b1);
		check_level("rx_got_nchar", rx_got_nchar, 1'b0); // Early data not counted

		// Data with markers, FCTs and NULLs in between
		for (int i = 0; i < N_DATA; i++)
		begin
			send_data(8'($urandom));
			pick = $urandom_range(7, 0);
			case (pick)
				0: send_ctrl(EOP);
				1: send_ctrl(EEP);
				2: send_ctrl(FCT);
				3: send_null();
				default: ;
			endcase
		end
		settle();
		check_level("rx_got_nchar", rx_got_nchar, 1'b1);
		check_drained("data characters");

		for (int i = 0; i < N_TIME; i++)
		begin
			send_time(8'($urandom));
			send_data(8'($urandom)); // Time code must hold across this
		end
		settle();
		check_drained("time codes");

		// Parity error, then nothing more decodes
		send_char(1'b0, 8'($urandom), 1'b1);
		send_data(8'($urandom));
		send_time(8'($urandom));
		settle();
		check_level("rx_error", rx_error, 1'b1);

		apply_reset();
		settle();
		check_level("rx_error", rx_error, 1'b0);
		send_null();
		send_data(8'($urandom));
		send_data(8'($urandom));
		send_ctrl(ESC);
		send_ctrl(EOP); // Escape error
		send_data(8'($urandom));
		send_time(8'($urandom));
		settle();
		check_level("rx_error", rx_error, 1'b1);
		check_drained("escape error");

		$display("Errors: value %0d, other %0d", val_errs, other_errs);
		if (val_errs + other_errs == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	initial
	begin : watchdog
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns with stimulus still running", WATCHDOG_NS);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
spw_char_pkg.sv
spw_rx_cfg_pkg.sv
spw_rx_bit_recovery.sv
spw_rx_char_shift.sv
spw_rx_parity.sv
spw_rx_char_fsm.sv
spw_rx_hold.sv
spw_rx_top.sv
tb_spw_rx.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= files.f
TB_TOP    ?= tb_spw_rx
RTL_TOP   ?= spw_rx_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@grep -q "Simulation passed" $(LOG) || (echo "Run ended early, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
